// ==== mul_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// Decode stage of the multiply path
// Accepts a word only while ready_o is high
// Illegal words are dropped and flagged one clock later
// The request stays put until the execute block takes it
//////////////////////////////////////////////////////////////////////

`include "mul_defs.svh"

module mul_decoder import mul_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid_i,
  input  logic [31:0]          instr_i,
  input  logic [`MUL_XLEN-1:0] rs1_data_i,
  input  logic [`MUL_XLEN-1:0] rs2_data_i,
  input  logic                 unit_ready_i,
  output mul_req_t             req_o,
  output logic                 req_valid_o,
  output logic                 ready_o,
  output logic                 illegal_o
);

  // Instruction fields
  logic [6:0]  opcode;
  logic [6:0]  funct7;
  logic [2:0]  funct3;

  // Decode results
  logic        legal;
  mul_opcode_e dec_op;
  logic [1:0]  dec_signed;

  // Handshake
  logic        accept;
  logic        consume;

  // Decode register
  mul_req_t    req_q;
  logic        req_valid_q;
  logic        illegal_q;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    legal      = 1'b0;
    dec_op     = MUL_M32;
    dec_signed = 2'b00;
    if ((opcode == `MUL_OPC_OP) && (funct7 == `MUL_F7_MULDIV)) begin
      case (funct3)
        `MUL_F3_MUL: begin
          legal = 1'b1;
        end
        // Signed x signed
        `MUL_F3_MULH: begin
          legal      = 1'b1;
          dec_op     = MUL_H;
          dec_signed = 2'b11;
        end
        // Signed rs1 x unsigned rs2
        `MUL_F3_MULHSU: begin
          legal      = 1'b1;
          dec_op     = MUL_H;
          dec_signed = 2'b01;
        end
        `MUL_F3_MULHU: begin
          legal  = 1'b1;
          dec_op = MUL_H;
        end
        // Divide and remainder stay illegal here
        default: legal = 1'b0;
      endcase
    end
  end

  // Free when empty or handing over this cycle
  assign consume = req_valid_q && unit_ready_i;
  assign ready_o = !req_valid_q || unit_ready_i;
  assign accept  = instr_valid_i && ready_o;

  ////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid_q <= 1'b0;
      illegal_q   <= 1'b0;
    end else begin
      illegal_q <= accept && !legal;
      if (accept && legal) begin
        req_valid_q <= 1'b1;
      end else if (consume) begin
        req_valid_q <= 1'b0;
      end
    end
  end

  // Payload follows the valid flag
  always_ff @(posedge clk) begin
    if (accept && legal) begin
      req_q.op           <= dec_op;
      req_q.short_signed <= dec_signed;
      req_q.rd           <= instr_i[11:7];
      req_q.op_a         <= rs1_data_i;
      req_q.op_b         <= rs2_data_i;
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;
  assign illegal_o   = illegal_q;

endmodule

// ==== mul_defs.svh ====
//////////////////////////////////////////////////////////////////////
// Widths and RV32M encodings for the multiply path
// Data width is fixed at 32, the halfword steps depend on it
// Only the OP major opcode with the MULDIV funct7 is recognized
//////////////////////////////////////////////////////////////////////

`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// Datapath and register index widths
`define MUL_XLEN   32
`define MUL_RIDX_W 5

// Major opcode and funct7 of the M extension
`define MUL_OPC_OP    7'b0110011
`define MUL_F7_MULDIV 7'b0000001

// funct3 values of the four multiplies
// Values 3'b100 to 3'b111 are divide and remainder
`define MUL_F3_MUL    3'b000
`define MUL_F3_MULH   3'b001
`define MUL_F3_MULHSU 3'b010
`define MUL_F3_MULHU  3'b011

`endif

// ==== mul_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types of the multiply path
// Field widths come from the defines header
// short_signed bit 0 marks rs1 signed, bit 1 marks rs2 signed
//////////////////////////////////////////////////////////////////////

`include "mul_defs.svh"

package mul_pkg;

  // Operation class seen by the execute block
  typedef enum logic {
    // Low word of the 32x32 product
    MUL_M32 = 1'b0,
    // High word of the 64-bit product
    MUL_H   = 1'b1
  } mul_opcode_e;

  // Steps of the halfword MULH sequence
  typedef enum logic [1:0] {
    ALBL = 2'b00,
    ALBH = 2'b01,
    AHBL = 2'b10,
    AHBH = 2'b11
  } mult_state_e;

  // Decoded request held in the decode register
  typedef struct packed {
    mul_opcode_e               op;
    // Ignored for MUL
    logic [1:0]                short_signed;
    logic [`MUL_RIDX_W-1:0]    rd;
    logic [`MUL_XLEN-1:0]      op_a;
    logic [`MUL_XLEN-1:0]      op_b;
  } mul_req_t;

  // Writeback beat
  typedef struct packed {
    logic [`MUL_RIDX_W-1:0]    rd;
    logic [`MUL_XLEN-1:0]      data;
  } mul_wb_t;

endpackage

// ==== mul_properties.sv ====
//////////////////////////////////////////////////////////////////////
// Interface checks on the multiply subsystem top
// Bound into every mul_subsystem_top instance
// assert_errors counts failures for the testbench summary
//////////////////////////////////////////////////////////////////////

module mul_properties import mul_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input logic    instr_valid_i,
  input logic    ready_o,
  input logic    illegal_o,
  input mul_wb_t wb_o,
  input logic    wb_valid_o,
  input logic    wb_ready_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int assert_errors = 0;

  // Strobe only into a free decode register
  a_no_strobe_busy: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_i |-> ready_o)
    else begin
      assert_errors++;
      $error("instr_valid_i high while ready_o low");
    end

  // Stalled writeback holds
  a_wb_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && !wb_ready_i) |=> (wb_valid_o && $stable(wb_o)))
    else begin
      assert_errors++;
      $error("wb_o changed or dropped under back-pressure");
    end

  // One cycle per accepted strobe, never without one
  a_illegal_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    illegal_o |-> $past(instr_valid_i && ready_o))
    else begin
      assert_errors++;
      $error("illegal_o high without an accepted strobe");
    end

  // Quiet outputs right after reset release
  a_reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> (!wb_valid_o && !illegal_o && ready_o))
    else begin
      assert_errors++;
      $error("outputs not idle after reset release");
    end

endmodule

bind mul_subsystem_top mul_properties i_properties (
  .clk           (clk),
  .rst_n         (rst_n),
  .instr_valid_i (instr_valid_i),
  .ready_o       (ready_o),
  .illegal_o     (illegal_o),
  .wb_o          (wb_o),
  .wb_valid_o    (wb_valid_o),
  .wb_ready_i    (wb_ready_i)
);

// ==== mul_result_stage.sv ====
//////////////////////////////////////////////////////////////////////
// One-entry result register in front of writeback
// Output holds stable until wb_ready_i is high
// A new result may load in the same cycle the old one drains
//////////////////////////////////////////////////////////////////////

module mul_result_stage import mul_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  mul_wb_t res_i,
  input  logic    res_valid_i,
  input  logic    wb_ready_i,
  output logic    stage_ready_o,
  output mul_wb_t wb_o,
  output logic    wb_valid_o
);

  // Entry and its flag
  mul_wb_t wb_q;
  logic    wb_valid_q;

  // Empty or draining this cycle
  assign stage_ready_o = !wb_valid_q || wb_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
    end else begin
      if (res_valid_i) begin
        wb_valid_q <= 1'b1;
      end else if (wb_ready_i) begin
        // Entry taken, nothing behind it
        wb_valid_q <= 1'b0;
      end
    end
  end

  // Producer only strobes while stage_ready_o is high
  always_ff @(posedge clk) begin
    if (res_valid_i) begin
      wb_q <= res_i;
    end
  end

  assign wb_o       = wb_q;
  assign wb_valid_o = wb_valid_q;

endmodule

// ==== mul_subsystem_top.sv ====
//////////////////////////////////////////////////////////////////////
// Multiply subsystem, decode then execute then result register
// Strobe instr_valid_i only while ready_o is high
// MUL latency 2 clocks, MULH family 5 clocks, without stalls
// Results leave in issue order
//////////////////////////////////////////////////////////////////////

`include "mul_defs.svh"

module mul_subsystem_top import mul_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid_i,
  input  logic [31:0]          instr_i,
  input  logic [`MUL_XLEN-1:0] rs1_data_i,
  input  logic [`MUL_XLEN-1:0] rs2_data_i,
  output logic                 ready_o,
  output logic                 illegal_o,
  output mul_wb_t              wb_o,
  output logic                 wb_valid_o,
  input  logic                 wb_ready_i
);

  // Decode to execute
  mul_req_t req;
  logic     req_valid;
  logic     unit_ready;

  // Execute to result
  mul_wb_t  res;
  logic     res_valid;
  logic     stage_ready;

  mul_decoder i_decoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .unit_ready_i  (unit_ready),
    .req_o         (req),
    .req_valid_o   (req_valid),
    .ready_o       (ready_o),
    .illegal_o     (illegal_o)
  );

  mul_unit i_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .ex_ready_i  (stage_ready),
    .res_o       (res),
    .res_valid_o (res_valid),
    .ready_o     (unit_ready)
  );

  mul_result_stage i_result (
    .clk           (clk),
    .rst_n         (rst_n),
    .res_i         (res),
    .res_valid_i   (res_valid),
    .wb_ready_i    (wb_ready_i),
    .stage_ready_o (stage_ready),
    .wb_o          (wb_o),
    .wb_valid_o    (wb_valid_o)
  );

endmodule

// ==== mul_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Execute block for MUL and the MULH family
// MUL completes combinationally in the request cycle
// MULH runs four halfword steps, one per clock, result in AHBH
// The request must stay on req_i until ready_o is seen high
// Completion waits for ex_ready_i in both cases
//////////////////////////////////////////////////////////////////////

`include "mul_defs.svh"

module mul_unit import mul_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  mul_req_t req_i,
  input  logic     req_valid_i,
  input  logic     ex_ready_i,
  output mul_wb_t  res_o,
  output logic     res_valid_o,
  output logic     ready_o
);

  // Shared 32-bit multiplier
  logic [`MUL_XLEN-1:0] op_a;
  logic [`MUL_XLEN-1:0] op_b;
  logic [33:0]          int_result;

  // Step sequencing
  mult_state_e          state_q;
  mult_state_e          state_d;
  logic                 mulh_start;
  logic                 mulh_shift;
  logic                 mulh_save;
  logic                 sum_load;
  logic                 sum_clear;

  // Halfword operands, bit 16 is the extension bit
  logic [16:0]          mulh_al;
  logic [16:0]          mulh_bl;
  logic [16:0]          mulh_ah;
  logic [16:0]          mulh_bh;
  logic [16:0]          mulh_a;
  logic [16:0]          mulh_b;

  // Running sum with its carry
  logic [`MUL_XLEN-1:0] sum_q;
  logic                 carry_q;
  logic [32:0]          mulh_c;
  logic [33:0]          mulh_sum;
  logic [33:0]          mulh_sum_shifted;
  logic [33:0]          mulh_result;

  ////////////////////////////////////////////////////////////////////
  // Halfword datapath
  ////////////////////////////////////////////////////////////////////

  // Low halves always unsigned
  assign mulh_al = {1'b0, req_i.op_a[15:0]};
  assign mulh_bl = {1'b0, req_i.op_b[15:0]};
  // Upper halves extend only for a signed operand
  assign mulh_ah = {req_i.short_signed[0] && req_i.op_a[31], req_i.op_a[31:16]};
  assign mulh_bh = {req_i.short_signed[1] && req_i.op_b[31], req_i.op_b[31:16]};

  assign mulh_c           = {carry_q, sum_q};
  assign mulh_sum         = $signed(int_result) + $signed(mulh_c);
  assign mulh_sum_shifted = $signed(mulh_sum) >>> 16;
  assign mulh_result      = mulh_shift ? mulh_sum_shifted : mulh_sum;

  assign mulh_start = req_valid_i && (req_i.op == MUL_H);

  always_comb begin
    state_d     = state_q;
    mulh_a      = mulh_al;
    mulh_b      = mulh_bl;
    mulh_shift  = 1'b0;
    mulh_save   = 1'b0;
    sum_load    = 1'b0;
    sum_clear   = 1'b0;
    ready_o     = ex_ready_i;
    res_valid_o = 1'b0;
    case (state_q)
      // Idle, also the MUL path
      ALBL: begin
        mulh_shift = 1'b1;
        if (mulh_start) begin
          ready_o  = 1'b0;
          sum_load = 1'b1;
          state_d  = ALBH;
        end else begin
          res_valid_o = req_valid_i && ex_ready_i;
        end
      end
      ALBH: begin
        mulh_b    = mulh_bh;
        mulh_save = 1'b1;
        sum_load  = 1'b1;
        ready_o   = 1'b0;
        state_d   = AHBL;
      end
      AHBL: begin
        mulh_a     = mulh_ah;
        mulh_shift = 1'b1;
        sum_load   = 1'b1;
        ready_o    = 1'b0;
        state_d    = AHBH;
      end
      // Final step, hold here until the result stage takes it
      AHBH: begin
        mulh_a = mulh_ah;
        mulh_b = mulh_bh;
        if (ex_ready_i) begin
          res_valid_o = 1'b1;
          sum_clear   = 1'b1;
          state_d     = ALBL;
        end
      end
      default: state_d = ALBL;
    endcase
  end

  // Sum restarts from zero for every sequence
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALBL;
      sum_q   <= '0;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      carry_q <= mulh_save && mulh_result[32];
      if (sum_clear) begin
        sum_q <= '0;
      end else if (sum_load) begin
        sum_q <= mulh_result[`MUL_XLEN-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // 32-bit multiplier and result select
  ////////////////////////////////////////////////////////////////////

  assign op_a = (req_i.op == MUL_M32) ? req_i.op_a : {{15{mulh_a[16]}}, mulh_a};
  assign op_b = (req_i.op == MUL_M32) ? req_i.op_b : {{15{mulh_b[16]}}, mulh_b};

  // Low word is the same for signed and unsigned MUL
  assign int_result = $signed(op_a) * $signed(op_b);

  assign res_o.rd   = req_i.rd;
  assign res_o.data = (req_i.op == MUL_M32) ? int_result[`MUL_XLEN-1:0]
                                            : mulh_result[`MUL_XLEN-1:0];

endmodule

// ==== sources.f ====
+incdir+.
mul_pkg.sv
mul_decoder.sv
mul_unit.sv
mul_result_stage.sv
mul_subsystem_top.sv
mul_properties.sv
tb_mul_subsystem.sv

// ==== tb_mul_subsystem.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the multiply subsystem
// Corner operands issued one at a time with latency checks
// Then back-to-back MUL and MULH, then a random mix with stalls
// Expected writebacks come from a 64-bit reference model
//////////////////////////////////////////////////////////////////////

`include "mul_defs.svh"

module tb_mul_subsystem import mul_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 40;
  localparam int N_CORNER   = 100;
  localparam int N_ALT      = 40;
  localparam int N_RANDOM   = 400;
  localparam int NUM_INSTR  = N_CORNER + N_ALT + N_RANDOM;

  // DUT ports
  logic        clk;
  logic        rst_n;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic [31:0] rs1_data_i;
  logic [31:0] rs2_data_i;
  logic        ready_o;
  logic        illegal_o;
  mul_wb_t     wb_o;
  logic        wb_valid_o;
  logic        wb_ready_i;

  // Operand corners
  logic [31:0] corner [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                              32'h8000_0000, 32'h7fff_ffff};

  // Model state, written only by the monitor
  mul_wb_t     exp_q [$];
  logic        illegal_exp;
  logic        held_valid;
  mul_wb_t     held_wb;

  // Error counters
  int          wb_errors;
  int          illegal_errors;
  int          latency_errors;
  int          other_errors;
  string       test_name;

  mul_subsystem_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .ready_o       (ready_o),
    .illegal_o     (illegal_o),
    .wb_o          (wb_o),
    .wb_valid_o    (wb_valid_o),
    .wb_ready_i    (wb_ready_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  // Only OP with MULDIV and funct3 below 4 is a multiply
  function automatic logic is_legal(input logic [31:0] instr);
    return (instr[6:0] == `MUL_OPC_OP) && (instr[31:25] == `MUL_F7_MULDIV) && !instr[14];
  endfunction

  // Extend per operand sign, 64-bit product, pick low or high word
  function automatic mul_wb_t model_result(input logic [31:0] instr, input logic [31:0] a,
                                           input logic [31:0] b);
    mul_wb_t     r;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = {32'b0, a};
    eb = {32'b0, b};
    case (instr[14:12])
      `MUL_F3_MULH: begin
        ea[63:32] = {32{a[31]}};
        eb[63:32] = {32{b[31]}};
      end
      // rs1 signed, rs2 unsigned
      `MUL_F3_MULHSU: ea[63:32] = {32{a[31]}};
      default: ;
    endcase
    p      = ea * eb;
    r.rd   = instr[11:7];
    r.data = (instr[14:12] == `MUL_F3_MUL) ? p[31:0] : p[63:32];
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] make_mul(input logic [2:0] f3);
    logic [31:0] r;
    r = $urandom;
    return {`MUL_F7_MULDIV, r[24:20], r[19:15], f3, r[11:7], `MUL_OPC_OP};
  endfunction

  // Mostly multiplies, some divides, OP-IMM and plain ADD words
  function automatic logic [31:0] rand_instr();
    logic [31:0] w;
    int          kind;
    kind = $urandom % 8;
    w    = make_mul({1'b0, 2'($urandom % 4)});
    if (kind == 0) begin
      w[14] = 1'b1;
    end else if (kind == 1) begin
      w[6:0] = 7'b0010011;
    end else if (kind == 2) begin
      w[31:25] = 7'b0000000;
    end
    return w;
  endfunction

  function automatic logic [31:0] pick_operand();
    if ($urandom % 4 == 0) begin
      return corner[$urandom % 5];
    end
    return $urandom;
  endfunction

  // Called right after a rising edge, returns on the next one
  task automatic step(input logic want, input logic [31:0] instr, input logic [31:0] a,
                      input logic [31:0] b, input logic rdy, output logic issued);
    #2;
    wb_ready_i = rdy;
    // ready_o depends on wb_ready_i through the stall path
    #1;
    issued        = want && ready_o;
    instr_valid_i = issued;
    instr_i       = instr;
    rs1_data_i    = a;
    rs2_data_i    = b;
    @(posedge clk);
  endtask

  // One instruction through an empty pipeline, edges counted from the sampling edge
  task automatic run_single(input logic [31:0] instr, input logic [31:0] a,
                            input logic [31:0] b, input int exp_lat);
    logic issued;
    logic seen;
    int   edges;
    step(1'b1, instr, a, b, 1'b1, issued);
    edges = 1;
    if (!issued) begin
      other_errors++;
      $display("ERROR: %s: ready_o was low with the pipeline empty", test_name);
    end
    #2;
    instr_valid_i = 1'b0;
    #1;
    seen = wb_valid_o;
    while (!seen && edges < 12) begin
      @(posedge clk);
      edges++;
      #3;
      seen = wb_valid_o;
    end
    if (seen) begin
      check_latency(test_name, exp_lat, edges);
    end else begin
      other_errors++;
      $display("ERROR: %s: no writeback appeared within 12 clock edges", test_name);
    end
    // Result drains on this edge
    @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////

  task automatic check_wb(input string name, input mul_wb_t exp, input mul_wb_t act);
    if (exp !== act) begin
      wb_errors++;
      $display("[FAIL] %s: expected rd=%0d data=%08h, actual rd=%0d data=%08h",
               name, exp.rd, exp.data, act.rd, act.data);
    end
  endtask

  task automatic check_illegal(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      illegal_errors++;
      $display("[FAIL] %s illegal_o: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (exp != act) begin
      latency_errors++;
      $display("[FAIL] %s latency: expected %0d edges, actual %0d edges", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Monitor, samples at the falling edge
  ////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      check_illegal(test_name, illegal_exp, illegal_o);
      illegal_exp = instr_valid_i && ready_o && !is_legal(instr_i);
      // Stalled output must not move
      if (held_valid) begin
        if (!wb_valid_o) begin
          other_errors++;
          $display("ERROR: %s: wb_valid_o dropped while wb_ready_i was low", test_name);
        end
        check_wb({test_name, " hold"}, held_wb, wb_o);
      end
      held_valid = wb_valid_o && !wb_ready_i;
      held_wb    = wb_o;
      if (instr_valid_i && ready_o && is_legal(instr_i)) begin
        exp_q.push_back(model_result(instr_i, rs1_data_i, rs2_data_i));
      end
      if (wb_valid_o && wb_ready_i) begin
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("ERROR: %s: writeback with no instruction outstanding", test_name);
        end else begin
          check_wb(test_name, exp_q.pop_front(), wb_o);
        end
      end
    end
  end

  // Run length bound
  initial begin
    #(NUM_INSTR * 20 * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d ns, the DUT stopped responding",
             NUM_INSTR * 20 * CLK_PERIOD);
    $display("Simulation FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    logic        issued;
    logic        want;
    logic        rdy;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    int          count;
    int          total;
    void'($urandom(32'hf11dd99f));
    clk            = 1'b0;
    rst_n          = 1'b0;
    instr_valid_i  = 1'b0;
    instr_i        = '0;
    rs1_data_i     = '0;
    rs2_data_i     = '0;
    wb_ready_i     = 1'b1;
    illegal_exp    = 1'b0;
    held_valid     = 1'b0;
    held_wb        = '0;
    wb_errors      = 0;
    illegal_errors = 0;
    latency_errors = 0;
    other_errors   = 0;
    test_name      = "reset";
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);

    // Every funct3 against every corner pair
    for (int f3 = 0; f3 < 4; f3++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          test_name = $sformatf("corner_f3_%0d_%0d_%0d", f3, i, j);
          run_single(make_mul(3'(f3)), corner[i], corner[j], (f3 == 0) ? 2 : 5);
        end
      end
    end

    // MUL and MULH family alternating, no stalls
    test_name = "alt_issue";
    count     = 0;
    while (count < N_ALT) begin
      w = (count % 2 == 0) ? make_mul(`MUL_F3_MUL) : make_mul(3'(1 + $urandom % 3));
      a = pick_operand();
      b = pick_operand();
      step(1'b1, w, a, b, 1'b1, issued);
      if (issued) begin
        count++;
      end
    end

    // Random words, gaps and back-pressure
    test_name = "random_mix";
    count     = 0;
    while (count < N_RANDOM) begin
      want = ($urandom % 4) != 0;
      rdy  = ($urandom % 3) != 0;
      w    = rand_instr();
      a    = pick_operand();
      b    = pick_operand();
      step(want, w, a, b, rdy, issued);
      if (issued) begin
        count++;
      end
    end

    test_name = "drain";
    while (exp_q.size() != 0) begin
      step(1'b0, '0, '0, '0, 1'b1, issued);
    end
    repeat (3) step(1'b0, '0, '0, '0, 1'b1, issued);

    total = wb_errors + illegal_errors + latency_errors + other_errors +
            i_dut.i_properties.assert_errors;
    $display("Errors: wb=%0d illegal=%0d latency=%0d other=%0d assertions=%0d",
             wb_errors, illegal_errors, latency_errors, other_errors,
             i_dut.i_properties.assert_errors);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
